//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Sizes of the shared instruction store
    localparam int addr_w    = 11;              // Enough to address every word of the memory
    localparam int instr_w   = 32;              // One instruction is one 32-bit word
    localparam int mem_depth = 1 << addr_w;     // 2048 words so the fetch address wraps on its own

    typedef logic [addr_w-1:0]  addr_t;         // Address used by loader, fetch and branches
    typedef logic [instr_w-1:0] instr_t;        // Raw instruction word as stored and delivered

    // The top bit of every word picks the core that executes it
    localparam int core_sel_bit = 31;           // Zero steers to core 0 and one steers to core 1

endpackage

`default_nettype wire

//--- src/cdc_pkg.sv
`default_nettype none

package cdc_pkg;

    localparam int sync_stages       = 2;                 // Flops in every synchronizer chain
    localparam int fifo_addr_w       = 3;                 // Index width of the per-core FIFO
    localparam int fifo_depth        = 1 << fifo_addr_w;  // Eight entries per core
    localparam int fifo_slack        = 2;                 // Free entries kept for words in flight
    localparam int flush_hold_cycles = 6;                 // Quiet sys_clk cycles after a branch

    // One extra bit beyond the index tells a full FIFO from an empty one
    typedef logic [fifo_addr_w:0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- src/instr_mem.sv
`default_nettype none

module instr_mem (
    input  logic            sys_clk,
    input  logic            load_en,       // Loader write strobe, only active while cores are off
    input  isa_pkg::addr_t  load_addr,
    input  isa_pkg::instr_t load_data,
    input  logic            fetch,         // Read request from the fetch counter
    input  isa_pkg::addr_t  fetch_addr,
    output isa_pkg::instr_t fetch_data,    // Word read one cycle after the request
    output logic            fetch_valid,   // Marks the cycle in which fetch_data is fresh
    input  logic            rst_n
);
    import isa_pkg::*;

    instr_t mem [mem_depth];               // Maps onto one block RAM

    // Loader port writes and fetch port reads share the clock
    always_ff @(posedge sys_clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;   // Loading and fetching never overlap in time
        end
    end

    always_ff @(posedge sys_clk) begin
        if (fetch) begin
            fetch_data <= mem[fetch_addr]; // Output register of the RAM
        end
    end

    // The valid flag follows the request by exactly one cycle
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= fetch;          // Router sees the word together with this flag
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_pc.sv
`default_nettype none

module fetch_pc (
    input  logic           sys_clk,
    input  logic           rst_n,
    input  logic           cpu_en,        // Fetch enable from the system side
    input  logic           stall,         // One of the core FIFOs is nearly full
    input  logic           branch,        // Branch pulse already moved into sys_clk
    input  isa_pkg::addr_t branch_addr,   // Stable for several cycles around the pulse
    output logic           fetch,         // Read request to the instruction memory
    output isa_pkg::addr_t fetch_addr,
    output logic           hold           // Flush window where fetches and writes are blocked
);
    import isa_pkg::*;
    import cdc_pkg::*;

    typedef logic [$clog2(flush_hold_cycles + 1)-1:0] hold_cnt_t;

    addr_t     pc;                        // Address of the next word to fetch
    hold_cnt_t hold_cnt;                  // Cycles left in the flush window

    // The branch cycle itself already counts as part of the hold
    assign hold       = branch || (hold_cnt != '0);
    assign fetch      = cpu_en && !stall && !hold;  // One word per cycle when all is clear
    assign fetch_addr = pc;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            pc       <= '0;
            hold_cnt <= '0;
        end else if (branch) begin
            pc       <= branch_addr;                  // New stream starts here after the hold
            hold_cnt <= hold_cnt_t'(flush_hold_cycles);
        end else begin
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - hold_cnt_t'(1);  // Give the flush time to reach the cores
            end
            if (fetch) begin
                pc <= pc + addr_t'(1);                // Wraps modulo mem_depth by its width
            end
        end
    end

    // While the hold counts down the stall input is ignored
    // since the FIFOs are being emptied anyway

endmodule

`default_nettype wire

//--- src/instr_router.sv
`default_nettype none

module instr_router (
    input  isa_pkg::instr_t fetch_data,    // Word coming out of the memory
    input  logic            fetch_valid,   // High in the cycle the word is fresh
    input  logic            hold,          // Flush window of the fetch counter
    output logic            push0,         // Write strobe of core 0 FIFO
    output logic            push1,         // Write strobe of core 1 FIFO
    output isa_pkg::instr_t push_data      // Shared write data of both FIFOs
);
    import isa_pkg::*;

    logic keep;                            // Word belongs to the live stream
    logic to_core1;                        // Core select bit of the word

    // Words that land during a flush are left over from the old stream
    assign keep     = fetch_valid && !hold;
    assign to_core1 = fetch_data[core_sel_bit];

    assign push0     = keep && !to_core1;  // Exactly one FIFO takes each kept word
    assign push1     = keep && to_core1;
    assign push_data = fetch_data;         // Both FIFOs see the word as it was stored

endmodule

`default_nettype wire

//--- src/pulse_sync.sv
`default_nettype none

module pulse_sync (
    input  logic src_clk,
    input  logic dst_clk,
    input  logic rst_n,
    input  logic src_pulse,                      // One-cycle pulse in the source domain
    output logic dst_pulse                       // One-cycle pulse in the destination domain
);
    import cdc_pkg::*;

    logic                   src_toggle;          // Flips once for every source pulse
    logic [sync_stages-1:0] sync_q;              // Two-flop chain in the destination domain
    logic                   dst_last;            // Previous synchronized toggle level

    always_ff @(posedge src_clk) begin
        if (!rst_n) begin
            src_toggle <= 1'b0;
        end else if (src_pulse) begin
            src_toggle <= ~src_toggle;           // A level survives any clock ratio
        end
    end

    // Any change of the synchronized level becomes one pulse again
    always_ff @(posedge dst_clk) begin
        if (!rst_n) begin
            sync_q    <= '0;
            dst_last  <= 1'b0;
            dst_pulse <= 1'b0;
        end else begin
            sync_q    <= {sync_q[sync_stages-2:0], src_toggle};
            dst_last  <= sync_q[sync_stages-1];
            dst_pulse <= sync_q[sync_stages-1] ^ dst_last;  // Lands sync_stages+1 edges later
        end
    end

endmodule

`default_nettype wire

//--- src/async_fifo.sv
`default_nettype none

module async_fifo (
    input  logic            wr_clk,        // System side that pushes fetched words
    input  logic            rd_clk,        // Core side that pops them
    input  logic            rst_n,
    input  logic            push,
    input  isa_pkg::instr_t push_data,
    input  logic            flush,         // Branch flush from the write side
    output logic            nearly_full,   // Fewer than fifo_slack free entries
    input  logic            pop,           // Ignored while empty
    output isa_pkg::instr_t head,          // Oldest word, valid while empty is low
    output logic            empty
);
    import isa_pkg::*;
    import cdc_pkg::*;

    instr_t    mem [fifo_depth];           // Small RAM with an asynchronous read
    fifo_ptr_t wr_bin;                     // Write pointer in binary for addressing
    fifo_ptr_t wr_gray;                    // Same pointer in Gray code for the crossing
    fifo_ptr_t wr_bin_next;
    fifo_ptr_t rd_bin;
    fifo_ptr_t rd_gray;
    fifo_ptr_t rd_bin_next;
    fifo_ptr_t rd_gray_wr [sync_stages];   // Read pointer moving into the write domain
    fifo_ptr_t wr_gray_rd [sync_stages];   // Write pointer moving into the read domain
    fifo_ptr_t rd_bin_wr;                  // Delayed read pointer as the write side sees it
    fifo_ptr_t wr_used;                    // Fill level as the write side sees it
    logic      rd_flush;                   // Flush pulse after its crossing
    logic      do_pop;

    function automatic fifo_ptr_t gray2bin(input fifo_ptr_t gray);
        fifo_ptr_t bin;
        bin[fifo_addr_w] = gray[fifo_addr_w];
        for (int k = fifo_addr_w - 1; k >= 0; k--) begin
            bin[k] = bin[k+1] ^ gray[k];   // Each binary bit folds in all higher Gray bits
        end
        return bin;
    endfunction

    assign wr_bin_next = wr_bin + fifo_ptr_t'(1);

    // A flush drops the write pointer at once
    always_ff @(posedge wr_clk) begin
        if (!rst_n || flush) begin
            wr_bin  <= '0;
            wr_gray <= '0;                 // This jump breaks Gray order but the read side resets too
        end else if (push) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push && !flush) begin
            mem[wr_bin[fifo_addr_w-1:0]] <= push_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < sync_stages; i++) begin
                rd_gray_wr[i] <= '0;
            end
        end else begin
            rd_gray_wr[0] <= rd_gray;
            for (int i = 1; i < sync_stages; i++) begin
                rd_gray_wr[i] <= rd_gray_wr[i-1];
            end
        end
    end

    // The stale read pointer can only overstate the fill level
    assign rd_bin_wr   = gray2bin(rd_gray_wr[sync_stages-1]);
    assign wr_used     = wr_bin - rd_bin_wr;
    assign nearly_full = wr_used > fifo_ptr_t'(fifo_depth - fifo_slack);

    pulse_sync i_flush_sync (
        .src_clk   (wr_clk),
        .dst_clk   (rd_clk),
        .rst_n     (rst_n),
        .src_pulse (flush),
        .dst_pulse (rd_flush)
    );

    assign do_pop      = pop && !empty;    // Pops on an empty FIFO do nothing
    assign rd_bin_next = rd_bin + fifo_ptr_t'(1);

    always_ff @(posedge rd_clk) begin
        if (!rst_n || rd_flush) begin
            rd_bin  <= '0;                 // Read side joins the write side at zero
            rd_gray <= '0;
        end else if (do_pop) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < sync_stages; i++) begin
                wr_gray_rd[i] <= '0;
            end
        end else begin
            wr_gray_rd[0] <= wr_gray;
            for (int i = 1; i < sync_stages; i++) begin
                wr_gray_rd[i] <= wr_gray_rd[i-1];
            end
        end
    end

    // Equal Gray pointers mean nothing new has arrived
    assign empty = (wr_gray_rd[sync_stages-1] == rd_gray);
    assign head  = mem[rd_bin[fifo_addr_w-1:0]];  // Written well before empty can fall

endmodule

`default_nettype wire

//--- src/dual_core_fetch.sv
`default_nettype none

module dual_core_fetch (
    input  logic            sys_clk,
    input  logic            core_clk,          // Must run at least as fast as sys_clk
    input  logic            rst_n,
    input  logic            cpu_en,            // Fetch enable in the sys_clk domain
    input  isa_pkg::instr_t w_instruction,     // Loader data
    input  isa_pkg::addr_t  w_adrs,            // Loader address
    input  logic            w_enable,          // Loader write strobe
    input  logic            read_fifo0,
    input  logic            read_fifo1,
    output isa_pkg::instr_t instruction0,
    output isa_pkg::instr_t instruction1,
    output logic            empty0,
    output logic            empty1,
    input  logic            branch_valid0,     // One core_clk cycle per branch
    input  logic            branch_valid1,
    input  isa_pkg::addr_t  branch_address0,
    input  isa_pkg::addr_t  branch_address1
);
    import isa_pkg::*;

    logic   load_en;                           // Loader strobe gated by the fetch enable
    logic   fetch;
    logic   fetch_valid;
    logic   hold;
    logic   stall;
    addr_t  fetch_addr;
    instr_t fetch_data;
    instr_t push_data;
    logic   push0;
    logic   push1;
    logic   nearly_full0;
    logic   nearly_full1;
    logic   branch_sys0;                       // Core 0 branch seen in sys_clk
    logic   branch_sys1;                       // Core 1 branch seen in sys_clk
    logic   branch_sys;
    addr_t  branch_addr_q;                     // Target latched on the core side

    assign load_en = w_enable && !cpu_en;      // Memory belongs to the loader only while stopped
    assign stall   = nearly_full0 || nearly_full1;  // Either full FIFO stops the shared fetch

    // Target is caught at the branch pulse and held while the pulse crosses
    always_ff @(posedge core_clk) begin
        if (branch_valid0) begin
            branch_addr_q <= branch_address0;  // Core 0 wins a tie
        end else if (branch_valid1) begin
            branch_addr_q <= branch_address1;
        end
    end

    pulse_sync i_branch_sync0 (
        .src_clk   (core_clk),
        .dst_clk   (sys_clk),
        .rst_n     (rst_n),
        .src_pulse (branch_valid0),
        .dst_pulse (branch_sys0)
    );

    pulse_sync i_branch_sync1 (
        .src_clk   (core_clk),
        .dst_clk   (sys_clk),
        .rst_n     (rst_n),
        .src_pulse (branch_valid1),
        .dst_pulse (branch_sys1)
    );

    assign branch_sys = branch_sys0 || branch_sys1;  // Reloads the counter and flushes both FIFOs

    instr_mem i_instr_mem (
        .sys_clk     (sys_clk),
        .load_en     (load_en),
        .load_addr   (w_adrs),
        .load_data   (w_instruction),
        .fetch       (fetch),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .rst_n       (rst_n)
    );

    fetch_pc i_fetch_pc (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cpu_en      (cpu_en),
        .stall       (stall),
        .branch      (branch_sys),
        .branch_addr (branch_addr_q),
        .fetch       (fetch),
        .fetch_addr  (fetch_addr),
        .hold        (hold)
    );

    instr_router i_instr_router (
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .hold        (hold),
        .push0       (push0),
        .push1       (push1),
        .push_data   (push_data)
    );

    async_fifo i_fifo0 (
        .wr_clk      (sys_clk),
        .rd_clk      (core_clk),
        .rst_n       (rst_n),
        .push        (push0),
        .push_data   (push_data),
        .flush       (branch_sys),
        .nearly_full (nearly_full0),
        .pop         (read_fifo0),
        .head        (instruction0),
        .empty       (empty0)
    );

    async_fifo i_fifo1 (
        .wr_clk      (sys_clk),
        .rd_clk      (core_clk),
        .rst_n       (rst_n),
        .push        (push1),
        .push_data   (push_data),
        .flush       (branch_sys),
        .nearly_full (nearly_full1),
        .pop         (read_fifo1),
        .head        (instruction1),
        .empty       (empty1)
    );

endmodule

`default_nettype wire

//--- verif/dual_core_fetch_sva.sv
`default_nettype none

module dual_core_fetch_sva (
    input  logic              wr_clk,
    input  logic              rd_clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic              flush,
    input  cdc_pkg::fifo_ptr_t wr_used,    // Fill level seen from the write side
    input  logic              pop,
    input  logic              empty,
    input  isa_pkg::instr_t   head,
    input  logic              rd_flush     // Flush after it reached the read side
);
    import cdc_pkg::*;

    // The slack keeps the word in flight from overrunning the FIFO
    no_overflow: assert property (@(posedge wr_clk) disable iff (!rst_n)
        push |-> (wr_used != fifo_ptr_t'(fifo_depth)))
        else $error("push into a full FIFO");

    // The router drops every word that lands in the flush cycle
    no_push_in_flush: assert property (@(posedge wr_clk) disable iff (!rst_n)
        push |-> !flush)
        else $error("push during a flush");

    head_stable: assert property (@(posedge rd_clk) disable iff (!rst_n)
        (!empty && !pop && !rd_flush) |=> $stable(head))
        else $error("head changed without a pop");

endmodule

bind async_fifo dual_core_fetch_sva i_fifo_sva (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rst_n    (rst_n),
    .push     (push),
    .flush    (flush),
    .wr_used  (wr_used),
    .pop      (pop),
    .empty    (empty),
    .head     (head),
    .rd_flush (rd_flush)
);

`default_nettype wire

//--- verif/dual_core_fetch_tb.sv
`default_nettype none

module dual_core_fetch_tb;
    import isa_pkg::*;

    localparam int max_cycles  = 60000;      // Loading takes 4096 cycles and the tests a few thousand
    localparam int branch_wait = 40;         // Core cycles a core waits out a flush

    logic   sys_clk;
    logic   core_clk;
    logic   rst_n;
    logic   cpu_en;
    instr_t w_instruction;
    addr_t  w_adrs;
    logic   w_enable;
    logic   read_fifo0 = 1'b0;
    logic   read_fifo1 = 1'b0;
    instr_t instruction0;
    instr_t instruction1;
    logic   empty0;
    logic   empty1;
    logic   branch_valid0;
    logic   branch_valid1;
    addr_t  branch_address0;
    addr_t  branch_address1;

    instr_t model [mem_depth];               // Reference copy of the instruction memory
    integer seed;
    int     errors, checks, tests, test_err0, cycle_cnt;
    int     rx0, rx1, exp_ptr0, exp_ptr1;    // Words received and next address to search from
    logic   pop_en0, pop_en1;                // Lets each core model pop
    string  test_name;

    dual_core_fetch i_dual_core_fetch (.*);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    initial begin
        core_clk = 1'b0;
        forever #7 core_clk = ~core_clk;     // Core side runs faster than the system side
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout after %0d sys_clk cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    // Next address at or after from whose word belongs to the given core
    function automatic int next_match(input int from, input logic want);
        int idx;
        for (int n = 0; n < mem_depth; n++) begin
            idx = (from + n) % mem_depth;
            if (model[idx][core_sel_bit] == want) return idx;
        end
        return -1;
    endfunction

    task automatic check_word(input int core, input instr_t got);
        int     a;
        instr_t exp_word;
        a = next_match((core == 0) ? exp_ptr0 : exp_ptr1, core == 1);
        exp_word = model[a];
        checks++;
        if (got !== exp_word) begin
            $display("Error in %s: core %0d address %0d expected %h actual %h",
                     test_name, core, a, exp_word, got);
            errors++;
        end
        if (core == 0) begin
            exp_ptr0 = a + 1;
            rx0++;
        end else begin
            exp_ptr1 = a + 1;
            rx1++;
        end
    endtask

    // Pops every other core cycle so the head is always read before it moves
    task automatic consume(input int core);
        forever begin
            @(posedge core_clk);
            if (core == 0) begin
                if (!rst_n || read_fifo0) read_fifo0 <= 1'b0;
                else if (pop_en0 && !empty0) begin
                    check_word(0, instruction0);
                    read_fifo0 <= 1'b1;
                end
            end else begin
                if (!rst_n || read_fifo1) read_fifo1 <= 1'b0;
                else if (pop_en1 && !empty1) begin
                    check_word(1, instruction1);
                    read_fifo1 <= 1'b1;
                end
            end
        end
    endtask

    task automatic core_cycles(input int n);
        repeat (n) @(posedge core_clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s done with %0d errors", test_name, errors - test_err0);
    endtask

    task automatic set_popping(input logic en0, input logic en1);
        @(posedge core_clk);
        pop_en0 <= en0;
        pop_en1 <= en1;
        core_cycles(4);                      // Lets a pending pop complete
    endtask

    task automatic wait_rx(input int n0, input int n1);
        int goal0, goal1, waited;
        goal0  = rx0 + n0;
        goal1  = rx1 + n1;
        waited = 0;
        while ((rx0 < goal0 || rx1 < goal1) && waited < 3000) begin
            @(posedge core_clk);
            waited++;
        end
        if (waited >= 3000) begin
            $display("%s: the cores stopped receiving words", test_name);
            errors++;
        end
    endtask

    task automatic load_word(input addr_t a, input instr_t w);
        @(posedge sys_clk);
        w_enable      <= 1'b1;
        w_adrs        <= a;
        w_instruction <= w;
        @(posedge sys_clk);
        w_enable      <= 1'b0;
    endtask

    // Both models are paused around the call so no stale word is popped
    task automatic send_branch(input logic v0, input logic v1, input addr_t a0, input addr_t a1,
                               input int target);
        @(posedge core_clk);
        branch_valid0   <= v0;
        branch_valid1   <= v1;
        branch_address0 <= a0;
        branch_address1 <= a1;
        @(posedge core_clk);
        branch_valid0   <= 1'b0;
        branch_valid1   <= 1'b0;
        exp_ptr0 = target;
        exp_ptr1 = target;
        core_cycles(branch_wait);
    endtask

    task automatic load_and_dispatch();
        begin_test("load_and_dispatch");
        for (int i = 0; i < mem_depth; i++) load_word(addr_t'(i), model[i]);
        @(posedge sys_clk);
        cpu_en <= 1'b1;
        set_popping(1'b1, 1'b1);
        wait_rx(60, 60);
        end_test();
    endtask

    task automatic back_pressure();
        int     held0;
        instr_t exp_head;
        begin_test("back_pressure");
        set_popping(1'b1, 1'b0);
        core_cycles(100);                    // Core 1 FIFO fills and core 0 drains
        held0 = rx0;
        core_cycles(50);
        if (rx0 != held0) begin
            $display("Error in %s: core 0 count expected %0d actual %0d", test_name, held0, rx0);
            errors++;
        end
        // The waiting head of core 1 is the next word of its stream
        exp_head = model[next_match(exp_ptr1, 1'b1)];
        if (empty1) begin
            $display("%s: core 1 FIFO ran empty while core 1 was not popping", test_name);
            errors++;
        end else if (instruction1 !== exp_head) begin
            $display("Error in %s: core 1 head expected %h actual %h",
                     test_name, exp_head, instruction1);
            errors++;
        end
        set_popping(1'b1, 1'b1);
        wait_rx(30, 30);
        end_test();
    endtask

    task automatic branch_core0();
        addr_t target;
        begin_test("branch_core0");
        target = addr_t'($random(seed));
        set_popping(1'b0, 1'b0);
        send_branch(1'b1, 1'b0, target, '0, int'(target));
        set_popping(1'b1, 1'b1);
        wait_rx(20, 20);
        end_test();
    endtask

    task automatic branch_both();
        addr_t t0, t1;
        begin_test("branch_both");
        t0 = addr_t'($random(seed));
        t1 = t0 + addr_t'(100);              // Different target that must lose
        set_popping(1'b0, 1'b0);
        send_branch(1'b1, 1'b1, t0, t1, int'(t0));
        set_popping(1'b1, 1'b1);
        wait_rx(20, 20);
        end_test();
    endtask

    task automatic fetch_enable();
        int     waited;
        logic   woke;
        addr_t  a;
        instr_t w;
        begin_test("fetch_enable");
        @(posedge sys_clk);
        cpu_en <= 1'b0;
        waited = 0;
        woke   = 1'b0;
        while (!(empty0 && empty1 && !read_fifo0 && !read_fifo1) && waited < 500) begin
            @(posedge core_clk);
            waited++;
        end
        core_cycles(10);                     // Last word in flight has arrived by now
        for (int i = 0; i < 30; i++) begin
            @(posedge core_clk);
            if (!empty0 || !empty1) woke = 1'b1;
        end
        if (waited >= 500 || woke) begin
            $display("%s: the FIFOs did not stay empty with fetch disabled", test_name);
            errors++;
        end
        set_popping(1'b0, 1'b0);
        a = addr_t'($random(seed));
        w = $random(seed);
        model[a] = w;
        load_word(a, w);
        @(posedge sys_clk);
        cpu_en <= 1'b1;
        send_branch(1'b1, 1'b0, a, '0, int'(a));
        set_popping(1'b1, 1'b1);
        wait_rx(20, 20);
        end_test();
    endtask

    task automatic wrap_around();
        begin_test("wrap_around");
        set_popping(1'b0, 1'b0);
        send_branch(1'b1, 1'b0, addr_t'(2040), '0, 2040);
        set_popping(1'b1, 1'b1);
        wait_rx(20, 20);
        end_test();
    endtask

    initial begin
        rst_n           = 1'b0;
        cpu_en          = 1'b0;
        w_instruction   = '0;
        w_adrs          = '0;
        w_enable        = 1'b0;
        branch_valid0   = 1'b0;
        branch_valid1   = 1'b0;
        branch_address0 = '0;
        branch_address1 = '0;
        pop_en0         = 1'b0;
        pop_en1         = 1'b0;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        cycle_cnt       = 0;
        rx0             = 0;
        rx1             = 0;
        exp_ptr0        = 0;
        exp_ptr1        = 0;
        seed            = 32'h0655_bcc4;
        for (int i = 0; i < mem_depth; i++) model[i] = $random(seed);
        fork
            consume(0);
            consume(1);
        join_none
        repeat (8) @(posedge sys_clk);
        rst_n <= 1'b1;
        load_and_dispatch();
        back_pressure();
        branch_core0();
        branch_both();
        fetch_enable();
        wrap_around();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_core_fetch.f
src/isa_pkg.sv
src/cdc_pkg.sv
src/instr_mem.sv
src/fetch_pc.sv
src/instr_router.sv
src/pulse_sync.sv
src/async_fifo.sv
src/dual_core_fetch.sv
verif/dual_core_fetch_sva.sv
verif/dual_core_fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dual_core_fetch_tb
FILELIST  ?= dual_core_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
